// File: sources.f
+incdir+source
source/fir_pkg.sv
source/sample_if.sv
source/sample_fifo.sv
source/shift_add_mult.sv
source/fir_symmetric.sv
source/fir_top.sv
sim/tb_fir_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_fir_top \
    -o tb_fir_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_fir_top > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: sim/tb_fir_top.sv
/*
 * Directed testbench for the FIR subsystem top level.
 * Writes samples through the buffer, models the filter as a plain
 * 16-tap convolution and compares every valid pulse in order.
 */
`default_nettype none

`include "fir_params.svh"

module tb_fir_top;
    timeunit 1ns;
    timeprecision 100ps;

    import fir_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 3;
    localparam int IMPULSE_AMP = 1000;
    localparam int STEP_COUNT = 20;
    localparam int RANDOM_COUNT = 200;
    localparam int BURST_COUNT = 6;
    localparam int OVER_COUNT = `FIR_FIFO_DEPTH + 3;
    localparam int STREAM_COUNT = 20;
    localparam int TOTAL_SAMPLES = `FIR_TAPS + STEP_COUNT + RANDOM_COUNT + BURST_COUNT
        + OVER_COUNT + STREAM_COUNT + `FIR_TAPS;
    localparam int WATCHDOG_NS = (TOTAL_SAMPLES + `FIR_LATENCY + 100) * CLK_PERIOD * 4;
    localparam int DRAIN_LIMIT = `FIR_LATENCY + `FIR_FIFO_DEPTH + 20;

    logic clk;
    logic rstn;
    logic sample_en;
    sample_t xin;
    logic run;
    logic full;
    logic dropped;
    logic valid;
    result_t yout;
    logic [`FIR_LVL_W-1:0] fifo_level;

    int exp_q[$];
    int model_line [`FIR_TAPS];
    int checks = 0;
    int errors_value = 0;
    int errors_other = 0;
    int valid_count = 0;
    logic [31:0] rnd_state = 32'h0d9dc7cc;

    fir_top dut (
        .clk        (clk),
        .rstn       (rstn),
        .sample_en  (sample_en),
        .xin        (xin),
        .run        (run),
        .full       (full),
        .dropped    (dropped),
        .valid      (valid),
        .yout       (yout),
        .fifo_level (fifo_level)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic sample_t next_sample();
        rnd_state = xorshift32(rnd_state);
        return sample_t'(rnd_state[15:0]);
    endfunction

    // impulse response h(i) mirrors around the middle of the filter.
    function automatic int tap_coef(input int i);
        return int'(fir_coef[(i < `FIR_TAPS / 2) ? i : `FIR_TAPS - 1 - i]);
    endfunction

    // shifts one sample into the model and returns the convolution.
    function automatic int model_shift(input int x);
        int y;
        for (int i = `FIR_TAPS - 1; i > 0; i--) begin
            model_line[i] = model_line[i-1];
        end
        model_line[0] = x;
        y = 0;
        for (int i = 0; i < `FIR_TAPS; i++) begin
            y += model_line[i] * tap_coef(i);
        end
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors_value++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_sample(input sample_t x);
        @(negedge clk);
        sample_en = 1'b1;
        xin = x;
    endtask

    task automatic stop_writes();
        @(negedge clk);
        sample_en = 1'b0;
    endtask

    task automatic accept_sample(input sample_t x);
        exp_q.push_back(model_shift(int'(x)));
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            errors_other++;
            $display("%0d expected results did not appear within %0d cycles",
                exp_q.size(), DRAIN_LIMIT);
            exp_q.delete();
        end
    endtask

    // outputs are registered on the rising edge, so look at them on the falling one.
    always @(negedge clk) begin
        if (rstn && valid) begin
            valid_count++;
            if (exp_q.size() == 0) begin
                errors_other++;
                $display("valid pulse at %0t with no result pending", $time);
            end else begin
                check("yout", yout, exp_q.pop_front());
            end
        end
    end

    // expects an empty delay line, so the outputs are the scaled taps.
    task automatic impulse_response();
        sample_t x;
        for (int i = 0; i < `FIR_TAPS; i++) begin
            x = (i == 0) ? sample_t'(IMPULSE_AMP) : '0;
            drive_sample(x);
            void'(model_shift(int'(x)));
            exp_q.push_back(IMPULSE_AMP * tap_coef(i));
        end
        stop_writes();
        wait_drain();
    endtask

    // the first step sample pushes the impulse out, so each output is a partial tap sum.
    task automatic step_response();
        int partial;
        partial = 0;
        for (int i = 0; i < STEP_COUNT; i++) begin
            drive_sample(sample_t'(1));
            void'(model_shift(1));
            if (i < `FIR_TAPS) begin
                partial += tap_coef(i);
            end
            exp_q.push_back(partial);
        end
        stop_writes();
        wait_drain();
    endtask

    task automatic random_stream();
        sample_t x;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            x = next_sample();
            if (i >= 120 && i < 136) begin
                x = 16'h8000;
            end else if (i % 20 == 0) begin
                x = 16'h7fff;
            end else if (i % 20 == 1) begin
                x = 16'h8000;
            end
            drive_sample(x);
            accept_sample(x);
        end
        stop_writes();
        wait_drain();
        check("dropped", dropped, 0);
    endtask

    task automatic buffered_burst();
        int seen;
        sample_t x;
        @(negedge clk);
        run = 1'b0;
        for (int i = 0; i < BURST_COUNT; i++) begin
            x = next_sample();
            drive_sample(x);
            accept_sample(x);
        end
        stop_writes();
        seen = valid_count;
        repeat (`FIR_LATENCY + 4) @(negedge clk);
        check("fifo_level", fifo_level, BURST_COUNT);
        check("valid_count", valid_count, seen);
        run = 1'b1;
        wait_drain();
    endtask

    // writes past the first FIR_FIFO_DEPTH are lost.
    task automatic overflow_drop();
        sample_t x;
        @(negedge clk);
        run = 1'b0;
        for (int i = 0; i < OVER_COUNT; i++) begin
            x = next_sample();
            drive_sample(x);
            if (i < `FIR_FIFO_DEPTH) begin
                accept_sample(x);
            end
        end
        stop_writes();
        check("full", full, 1);
        check("dropped", dropped, 1);
        check("fifo_level", fifo_level, `FIR_FIFO_DEPTH);
        run = 1'b1;
        wait_drain();
        check("full", full, 0);
    endtask

    task automatic reset_recovery();
        sample_t x;
        for (int i = 0; i < STREAM_COUNT; i++) begin
            x = next_sample();
            drive_sample(x);
            accept_sample(x);
        end
        // results are still in flight here.
        @(negedge clk);
        sample_en = 1'b0;
        rstn = 1'b0;
        exp_q.delete();
        for (int i = 0; i < `FIR_TAPS; i++) begin
            model_line[i] = 0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check("dropped", dropped, 0);
        check("full", full, 0);
        check("valid", valid, 0);
        impulse_response();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before the tests finished", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        sample_en = 1'b0;
        xin = '0;
        run = 1'b0;
        for (int i = 0; i < `FIR_TAPS; i++) begin
            model_line[i] = 0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        run = 1'b1;
        impulse_response();
        step_response();
        random_stream();
        buffered_burst();
        overflow_drop();
        reset_recovery();
        repeat (4) @(negedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
            checks, errors_value, errors_other);
        if (errors_value + errors_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/fir_top.sv
/*
 * Top level of the FIR subsystem. The producer writes samples with
 * sample_en and watches full; run lets the filter drain the buffer.
 */
`default_nettype none

`include "fir_params.svh"

module fir_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  sample_en,
    input  fir_pkg::sample_t      xin,
    input  logic                  run,
    output logic                  full,
    output logic                  dropped,
    output logic                  valid,
    output fir_pkg::result_t      yout,
    output logic [`FIR_LVL_W-1:0] fifo_level
);
    import fir_pkg::*;

    sample_if u_link ();

    sample_fifo #(
        .payload_t(sample_t)
    ) u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (sample_en),
        .wr_data (xin),
        .full    (full),
        .dropped (dropped),
        .rd      (u_link.buffer)
    );

    fir_symmetric u_fir (
        .clk   (clk),
        .rstn  (rstn),
        .run   (run),
        .src   (u_link.filter),
        .valid (valid),
        .yout  (yout)
    );

    assign fifo_level = u_link.level;

endmodule

`default_nettype wire

// File: source/fir_symmetric.sv
/*
 * Folded 16-tap FIR. Pops one sample per cycle while run is high,
 * adds mirrored taps, multiplies each pair sum by its coefficient
 * and sums the eight products through a registered adder tree.
 */
`default_nettype none

`include "fir_params.svh"

module fir_symmetric (
    input  logic             clk,
    input  logic             rstn,
    input  logic             run,
    sample_if.filter         src,
    output logic             valid,
    output fir_pkg::result_t yout
);
    import fir_pkg::*;

    localparam int NPAIR = `FIR_TAPS / 2;

    logic pop_d;
    logic tap_vld;
    sample_t taps [`FIR_TAPS];
    pair_t pair_sum [NPAIR];
    prod_t prod [NPAIR];
    logic [NPAIR-1:0] prod_rdy;
    result_t sum1 [NPAIR/2];
    result_t sum2 [NPAIR/4];
    logic [1:0] tree_vld;

    // the pipeline never stalls, so popping only depends on run and empty.
    assign src.pop = run && !src.empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pop_d <= 1'b0;
            tap_vld <= 1'b0;
            tree_vld <= '0;
            valid <= 1'b0;
        end else begin
            pop_d <= src.pop;
            tap_vld <= pop_d;
            tree_vld <= {tree_vld[0], prod_rdy[0]};
            valid <= tree_vld[1];
        end
    end

    // taps[0] holds the newest sample.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `FIR_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (pop_d) begin
            taps[0] <= src.data;
            for (int i = 1; i < `FIR_TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // pre-add feeds the first multiplier stage directly.
    for (genvar k = 0; k < NPAIR; k++) begin : g_pair
        assign pair_sum[k] = taps[k] + taps[`FIR_TAPS-1-k];

        shift_add_mult #(
            .A_W(`FIR_XW + 1),
            .B_W(`FIR_CW)
        ) u_mult (
            .clk      (clk),
            .rstn     (rstn),
            .data_rdy (tap_vld),
            .mult1    (pair_sum[k]),
            .mult2    (fir_coef[k]),
            .res_rdy  (prod_rdy[k]),
            .res      (prod[k])
        );
    end

    // eight products fold to four and then two before the output register adds the last pair.
    always_ff @(posedge clk) begin
        if (prod_rdy[0]) begin
            for (int k = 0; k < NPAIR / 2; k++) begin
                sum1[k] <= prod[2*k] + prod[2*k+1];
            end
        end
        if (tree_vld[0]) begin
            for (int k = 0; k < NPAIR / 4; k++) begin
                sum2[k] <= sum1[2*k] + sum1[2*k+1];
            end
        end
        if (tree_vld[1]) begin
            yout <= sum2[0] + sum2[1];
        end
    end

    a_rdy_agree: assert property (@(posedge clk) disable iff (!rstn)
        (prod_rdy == '0) || (&prod_rdy));

endmodule

`default_nettype wire

// File: source/shift_add_mult.sv
/*
 * Pipelined signed shift-add multiplier, one stage per bit of mult2.
 * A new operand pair may enter every cycle; res_rdy follows data_rdy
 * by exactly B_W cycles.
 */
`default_nettype none

module shift_add_mult #(
    parameter int A_W = 17,
    parameter int B_W = 12
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     data_rdy,
    input  logic signed [A_W-1:0]    mult1,
    input  logic signed [B_W-1:0]    mult2,
    output logic                     res_rdy,
    output logic signed [A_W+B_W-1:0] res
);

    localparam int P_W = A_W + B_W;

    logic signed [P_W-1:0] acc [B_W];
    logic signed [P_W-1:0] mcand [B_W-1];
    logic [B_W-1:0] mplier [B_W-1];
    logic [B_W-1:0] rdy;
    logic signed [P_W-1:0] mult1_ext;

    assign mult1_ext = {{B_W{mult1[A_W-1]}}, mult1};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy <= '0;
        end else begin
            rdy <= {rdy[B_W-2:0], data_rdy};
        end
    end

    // stage 0 looks at bit 0 straight from the operand.
    always_ff @(posedge clk) begin
        acc[0] <= mult2[0] ? mult1_ext : '0;
        mcand[0] <= mult1_ext;
        mplier[0] <= mult2;
    end

    for (genvar i = 1; i < B_W; i++) begin : g_stage
        logic signed [P_W-1:0] term;

        assign term = mplier[i-1][i] ? (mcand[i-1] <<< i) : '0;

        if (i == B_W - 1) begin : g_sign
            // sign bit carries negative weight.
            always_ff @(posedge clk) begin
                acc[i] <= acc[i-1] - term;
            end
        end else begin : g_mid
            always_ff @(posedge clk) begin
                acc[i] <= acc[i-1] + term;
                mcand[i] <= mcand[i-1];
                mplier[i] <= mplier[i-1];
            end
        end
    end

    assign res = acc[B_W-1];
    assign res_rdy = rdy[B_W-1];

endmodule

`default_nettype wire

// File: source/sample_fifo.sv
/*
 * Circular sample buffer between the producer and the filter.
 * Writes are plain strobes; a write into a full buffer is lost and
 * sets the sticky dropped flag. Pops return data one cycle later.
 */
`default_nettype none

`include "fir_params.svh"

module sample_fifo #(
    parameter type payload_t = fir_pkg::sample_t
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     wr_en,
    input  payload_t wr_data,
    output logic     full,
    output logic     dropped,
    sample_if.buffer rd
);

    localparam int DEPTH = `FIR_FIFO_DEPTH;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [`FIR_LVL_W-1:0] count;
    logic do_wr;
    logic do_rd;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == `FIR_LVL_W'(DEPTH));
    assign rd.empty = (count == '0);
    assign rd.level = count;

    // a pop frees the slot in the same cycle, so full plus pop still writes.
    assign do_wr = wr_en && (!full || rd.pop);
    assign do_rd = rd.pop && !rd.empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            dropped <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
            if (wr_en && !do_wr) begin
                dropped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd.data <= mem[rd_ptr];
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        rd.pop |-> !rd.empty);

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= `FIR_LVL_W'(DEPTH));

endmodule

`default_nettype wire

// File: source/sample_if.sv
/*
 * Link between the sample FIFO and the filter.
 * The filter pops, the FIFO returns data one cycle later.
 */
`default_nettype none

`include "fir_params.svh"

interface sample_if;
    import fir_pkg::*;

    logic pop;
    sample_t data;
    logic empty;
    logic [`FIR_LVL_W-1:0] level;

    modport buffer (input pop, output data, output empty, output level);

    modport filter (output pop, input data, input empty);

endinterface

`default_nettype wire

// File: source/fir_pkg.sv
/*
 * Data types and the coefficient table of the symmetric FIR.
 * Designs import it in their body; ports use scoped names.
 */
`default_nettype none

`include "fir_params.svh"

package fir_pkg;

    typedef logic signed [`FIR_XW-1:0] sample_t;
    typedef logic signed [`FIR_XW:0] pair_t;
    typedef logic signed [`FIR_CW-1:0] coef_t;

    // pair sum times coefficient.
    typedef logic signed [`FIR_XW+`FIR_CW:0] prod_t;

    // room for the sum of eight products.
    typedef logic signed [`FIR_XW+`FIR_CW+2:0] result_t;

    // first half of the impulse response.
    // tap i and tap 15-i share entry i.
    localparam coef_t fir_coef [`FIR_TAPS/2] = '{
        -32, 10, 62, 121, 179, 230, 269, 289
    };

endpackage

`default_nettype wire

// File: source/fir_params.svh
/*
 * Build-time constants for the symmetric FIR subsystem.
 * Include this wherever a width, tap count or pipeline depth is needed.
 */
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// sample and coefficient widths.
`define FIR_XW 16
`define FIR_CW 12

// the folded structure needs an even filter length.
`define FIR_TAPS 16

`define FIR_FIFO_DEPTH 8
`define FIR_LVL_W $clog2(`FIR_FIFO_DEPTH + 1)

// one shift-add stage per coefficient bit.
`define FIR_MULT_STAGES `FIR_CW

// pop to valid, in clock cycles.
`define FIR_LATENCY (`FIR_MULT_STAGES + 5)

`endif
